/* axi_sram.f */
+incdir+include
design/axi_sram_pkg.sv
design/sram.sv
design/axi_write_ctrl.sv
design/axi_read_ctrl.sv
design/axi_sram_bridge.sv
design/axi_sram_top.sv
verif/axi_sram_checker.sv
verif/axi_sram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the axi sram testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -j 0 \
   --timescale 1ns/100ps \
   --top-module axi_sram_tb \
   --Mdir "$build_dir" -o axi_sram_sim \
   -f axi_sram.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/axi_sram_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
   exit 0
else
   echo "pass message not found in $log_file"
   exit 1
fi

/* verif/axi_sram_tb.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_tb;
   import axi_sram_pkg::*;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_TXN         = 18;
   localparam int WATCHDOG_CYCLES = NUM_TXN * 40 + RESET_CYCLES;

   typedef struct packed {
      logic [8*24-1:0]        name;
      logic                   is_write;
      logic [`AXI_ID_W-1:0]   id;
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
      axi_size_t              size;
      axi_burst_t             burst;
      logic [3:0]             strb;
      logic [7:0]             stall;
   } txn_t;

   logic                   clk = 1'b0;
   logic                   resetn;
   logic [`AXI_ID_W-1:0]   awid;
   logic [`AXI_ADDR_W-1:0] awaddr;
   logic [`AXI_LEN_W-1:0]  awlen;
   axi_size_t              awsize;
   axi_burst_t             awburst;
   logic                   awvalid;
   logic                   awready;
   logic [`AXI_DATA_W-1:0] wdata;
   logic [`AXI_STRB_W-1:0] wstrb;
   logic                   wlast;
   logic                   wvalid;
   logic                   wready;
   logic [`AXI_ID_W-1:0]   bid;
   axi_resp_t              bresp;
   logic                   bvalid;
   logic                   bready;
   logic [`AXI_ID_W-1:0]   arid;
   logic [`AXI_ADDR_W-1:0] araddr;
   logic [`AXI_LEN_W-1:0]  arlen;
   axi_size_t              arsize;
   axi_burst_t             arburst;
   logic                   arvalid;
   logic                   arready;
   logic [`AXI_ID_W-1:0]   rid;
   logic [`AXI_DATA_W-1:0] rdata;
   axi_resp_t              rresp;
   logic                   rlast;
   logic                   rvalid;
   logic                   rready;
   logic [8*24-1:0]        test_name;
   int                     check_count;
   int                     error_count;
   txn_t                   txns [NUM_TXN];
   logic [31:0]            rng_state;

   axi_sram_top axi_sram_top_i (.*);

   axi_sram_checker axi_sram_checker_i (.*);

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [`AXI_ADDR_W-1:0] next_beat_addr(
      input logic [`AXI_ADDR_W-1:0] addr,
      input axi_size_t              size,
      input axi_burst_t             burst
   );
      if (burst == FIXED)
         return addr;
      return addr + (`AXI_ADDR_W'(1) << size);
   endfunction

   // narrow beats use the lanes of their address, full words rotate the row strobe
   function automatic logic [3:0] lane_strobe(
      input logic [`AXI_ADDR_W-1:0] addr,
      input axi_size_t              size,
      input logic [3:0]             strb,
      input logic [1:0]             rot
   );
      logic [7:0] doubled;
      doubled = {strb, strb} << rot;
      case (size)
         3'd0:    return 4'b0001 << addr[1:0];
         3'd1:    return 4'b0011 << {addr[1], 1'b0};
         default: return doubled[7:4];
      endcase
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic set_row(
      input int                     idx,
      input logic [8*24-1:0]        name,
      input logic                   is_write,
      input logic [`AXI_ID_W-1:0]   id,
      input logic [`AXI_ADDR_W-1:0] addr,
      input logic [`AXI_LEN_W-1:0]  len,
      input axi_size_t              size,
      input axi_burst_t             burst,
      input logic [3:0]             strb,
      input logic [7:0]             stall
   );
      txns[idx] = '{name, is_write, id, addr, len, size, burst, strb, stall};
   endtask

   // name, write, id, address, len, size, burst, strobe, ready pattern
   task automatic load_table();
      set_row(0,  "single_wr",      1'b1, 4'd1,  32'h0000_0100, 4'd0,  3'd2, INCR,  4'hf, 8'hff);
      set_row(1,  "single_rd",      1'b0, 4'd2,  32'h0000_0100, 4'd0,  3'd2, INCR,  4'h0, 8'hff);
      set_row(2,  "word_fill_wr",   1'b1, 4'd3,  32'h0000_0200, 4'd0,  3'd2, INCR,  4'hf, 8'hff);
      set_row(3,  "byte_strb_wr",   1'b1, 4'd4,  32'h0000_0200, 4'd0,  3'd2, INCR,  4'h5, 8'hff);
      set_row(4,  "narrow_byte_wr", 1'b1, 4'd5,  32'h0000_0203, 4'd0,  3'd0, INCR,  4'h0, 8'hff);
      set_row(5,  "narrow_half_wr", 1'b1, 4'd6,  32'h0000_0200, 4'd0,  3'd1, INCR,  4'h0, 8'hff);
      set_row(6,  "narrow_rd",      1'b0, 4'd7,  32'h0000_0200, 4'd0,  3'd2, INCR,  4'h0, 8'hff);
      set_row(7,  "byte_burst_wr",  1'b1, 4'd8,  32'h0000_0204, 4'd3,  3'd0, INCR,  4'h0, 8'hff);
      set_row(8,  "byte_burst_rd",  1'b0, 4'd9,  32'h0000_0204, 4'd0,  3'd2, INCR,  4'h0, 8'hff);
      set_row(9,  "incr16_wr",      1'b1, 4'd10, 32'h0000_1000, 4'd15, 3'd2, INCR,  4'hf, 8'hdb);
      set_row(10, "incr16_rd",      1'b0, 4'd11, 32'h0000_1000, 4'd15, 3'd2, INCR,  4'h0, 8'hff);
      set_row(11, "fixed4_wr",      1'b1, 4'd12, 32'h0000_0300, 4'd3,  3'd2, FIXED, 4'h1, 8'hff);
      set_row(12, "fixed4_rd",      1'b0, 4'd13, 32'h0000_0300, 4'd0,  3'd2, INCR,  4'h0, 8'hff);
      set_row(13, "stall_incr_rd",  1'b0, 4'd14, 32'h0000_1000, 4'd15, 3'd2, INCR,  4'h0, 8'h69);
      set_row(14, "stall_fixed_rd", 1'b0, 4'd15, 32'h0000_1010, 4'd3,  3'd2, FIXED, 4'h0, 8'h25);
      set_row(15, "alias_wr",       1'b1, 4'd0,  32'h0000_8400, 4'd1,  3'd2, INCR,  4'hf, 8'hff);
      set_row(16, "alias_rd",       1'b0, 4'd1,  32'h0000_0400, 4'd1,  3'd2, INCR,  4'h0, 8'hff);
      set_row(17, "alias_hi_rd",    1'b0, 4'd2,  32'hffff_8400, 4'd1,  3'd2, INCR,  4'h0, 8'h55);
   endtask

   // handshakes are sampled at the falling edge, where all inputs are settled
   task automatic write_burst(input txn_t t);
      logic [`AXI_ADDR_W-1:0] beat_addr;
      logic [2:0]             cyc;
      logic                   done;
      awid    = t.id;
      awaddr  = t.addr;
      awlen   = t.len;
      awsize  = t.size;
      awburst = t.burst;
      awvalid = 1'b1;
      done    = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         done = awready;
         next_cycle();
      end
      awvalid   = 1'b0;
      beat_addr = t.addr;
      for (int beat = 0; beat <= int'(t.len); beat++)
      begin
         rng_state = xorshift32(rng_state);
         wdata     = rng_state;
         wstrb     = lane_strobe(beat_addr, t.size, t.strb, beat[1:0]);
         wlast     = (beat == int'(t.len));
         wvalid    = 1'b1;
         done      = 1'b0;
         while (!done)
         begin
            @(negedge clk);
            done = wready;
            next_cycle();
         end
         beat_addr = next_beat_addr(beat_addr, t.size, t.burst);
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      cyc    = '0;
      done   = 1'b0;
      while (!done)
      begin
         bready = t.stall[cyc];
         @(negedge clk);
         done = bvalid && bready;
         next_cycle();
         cyc = cyc + 3'd1;
      end
      bready = 1'b0;
   endtask

   task automatic read_burst(input txn_t t);
      logic [2:0] cyc;
      logic       done;
      int         beats;
      arid    = t.id;
      araddr  = t.addr;
      arlen   = t.len;
      arsize  = t.size;
      arburst = t.burst;
      arvalid = 1'b1;
      done    = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         done = arready;
         next_cycle();
      end
      arvalid = 1'b0;
      cyc     = '0;
      beats   = 0;
      while (beats <= int'(t.len))
      begin
         rready = t.stall[cyc];
         @(negedge clk);
         if (rvalid && rready)
            beats++;
         next_cycle();
         cyc = cyc + 3'd1;
      end
      rready = 1'b0;
   endtask

   initial
   begin
      resetn    = 1'b0;
      awid      = '0;
      awaddr    = '0;
      awlen     = '0;
      awsize    = '0;
      awburst   = INCR;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wlast     = 1'b0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      arid      = '0;
      araddr    = '0;
      arlen     = '0;
      arsize    = '0;
      arburst   = INCR;
      arvalid   = 1'b0;
      rready    = 1'b0;
      test_name = "reset";
      rng_state = 32'ha1c1_e960;
      load_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      resetn = 1'b1;
      next_cycle();
      for (int i = 0; i < NUM_TXN; i++)
      begin
         test_name = txns[i].name;
         if (txns[i].is_write)
            write_burst(txns[i]);
         else
            read_burst(txns[i]);
      end
      repeat (2) next_cycle();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: transactions still running after %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* verif/axi_sram_checker.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_checker (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [8*24-1:0]          test_name,
   input  logic [`AXI_ID_W-1:0]     awid,
   input  logic [`AXI_ADDR_W-1:0]   awaddr,
   input  axi_sram_pkg::axi_size_t  awsize,
   input  axi_sram_pkg::axi_burst_t awburst,
   input  logic                     awvalid,
   input  logic                     awready,
   input  logic [`AXI_DATA_W-1:0]   wdata,
   input  logic [`AXI_STRB_W-1:0]   wstrb,
   input  logic                     wvalid,
   input  logic                     wready,
   input  logic [`AXI_ID_W-1:0]     bid,
   input  axi_sram_pkg::axi_resp_t  bresp,
   input  logic                     bvalid,
   input  logic                     bready,
   input  logic [`AXI_ID_W-1:0]     arid,
   input  logic [`AXI_ADDR_W-1:0]   araddr,
   input  logic [`AXI_LEN_W-1:0]    arlen,
   input  axi_sram_pkg::axi_size_t  arsize,
   input  axi_sram_pkg::axi_burst_t arburst,
   input  logic                     arvalid,
   input  logic                     arready,
   input  logic [`AXI_ID_W-1:0]     rid,
   input  logic [`AXI_DATA_W-1:0]   rdata,
   input  axi_sram_pkg::axi_resp_t  rresp,
   input  logic                     rlast,
   input  logic                     rvalid,
   input  logic                     rready,
   output int                       check_count,
   output int                       error_count
);
   import axi_sram_pkg::*;

   // shadow copy of the sram contents
   logic [`AXI_DATA_W-1:0] shadow [0:(2**`RAM_ADDR_W)-1];
   logic [`AXI_ID_W-1:0]   wr_id;
   logic [`AXI_ADDR_W-1:0] wr_addr;
   axi_size_t              wr_size;
   axi_burst_t             wr_burst;
   logic [`AXI_ID_W-1:0]   rd_id;
   logic [`AXI_ADDR_W-1:0] rd_addr;
   logic [`AXI_LEN_W-1:0]  rd_len;
   logic [`AXI_LEN_W-1:0]  rd_beat;
   axi_size_t              rd_size;
   axi_burst_t             rd_burst;
   logic                   rd_open;

   function automatic logic [`AXI_ADDR_W-1:0] beat_step(
      input logic [`AXI_ADDR_W-1:0] addr,
      input axi_size_t              size,
      input axi_burst_t             burst
   );
      if (burst == FIXED)
         return addr;
      return addr + (`AXI_ADDR_W'(1) << size);
   endfunction

   // word index from bits 2 and up so high addresses fold back
   function automatic logic [`RAM_ADDR_W-1:0] word_of(input logic [`AXI_ADDR_W-1:0] addr);
      return addr[`RAM_ADDR_W+1:2];
   endfunction

   function automatic string name_text(input logic [8*24-1:0] packed_name);
      string s;
      s = "";
      for (int i = 23; i >= 0; i--)
      begin
         if (packed_name[i*8 +: 8] != 8'd0)
            s = $sformatf("%s%c", s, packed_name[i*8 +: 8]);
      end
      return s;
   endfunction

   task automatic compare(
      input string       what,
      input logic [31:0] expected,
      input logic [31:0] actual
   );
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("[ERROR] %s %s: expected 0x%h, actual 0x%h",
                  name_text(test_name), what, expected, actual);
      end
   endtask

   task automatic report(input string msg);
      error_count++;
      $display("%s: %s", name_text(test_name), msg);
   endtask

   always @(posedge clk)
   begin
      if (!resetn)
      begin
         check_count = 0;
         error_count = 0;
         rd_open     = 1'b0;
      end
      else
      begin
         // read channel stays quiet outside a burst
         if (rvalid && !rd_open)
            report("rvalid was high with no read burst open");
         if (arready && rd_open)
            report("arready was high while a read burst was still open");

         if (awvalid && awready)
         begin
            wr_id    = awid;
            wr_addr  = awaddr;
            wr_size  = awsize;
            wr_burst = awburst;
         end
         if (wvalid && wready)
         begin
            for (int i = 0; i < `AXI_STRB_W; i++)
            begin
               if (wstrb[i])
                  shadow[word_of(wr_addr)][i*8 +: 8] = wdata[i*8 +: 8];
            end
            wr_addr = beat_step(wr_addr, wr_size, wr_burst);
         end
         if (bvalid && bready)
         begin
            compare("bid", 32'(wr_id), 32'(bid));
            compare("bresp", 32'(OKAY), 32'(bresp));
         end

         // beats of the open burst come before any new request
         if (rvalid && rready && rd_open)
         begin
            compare("rid", 32'(rd_id), 32'(rid));
            compare("rresp", 32'(OKAY), 32'(rresp));
            compare("rdata", shadow[word_of(rd_addr)], rdata);
            compare("rlast", 32'(rd_beat == rd_len), 32'(rlast));
            if (rd_beat == rd_len)
               rd_open = 1'b0;
            rd_beat = rd_beat + 1'b1;
            rd_addr = beat_step(rd_addr, rd_size, rd_burst);
         end
         if (arvalid && arready)
         begin
            rd_id    = arid;
            rd_addr  = araddr;
            rd_len   = arlen;
            rd_size  = arsize;
            rd_burst = arburst;
            rd_beat  = '0;
            rd_open  = 1'b1;
         end
      end
   end

endmodule

/* design/axi_sram_top.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_top (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [`AXI_ID_W-1:0]     awid,
   input  logic [`AXI_ADDR_W-1:0]   awaddr,
   input  logic [`AXI_LEN_W-1:0]    awlen,
   input  axi_sram_pkg::axi_size_t  awsize,
   input  axi_sram_pkg::axi_burst_t awburst,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`AXI_DATA_W-1:0]   wdata,
   input  logic [`AXI_STRB_W-1:0]   wstrb,
   input  logic                     wlast,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [`AXI_ID_W-1:0]     bid,
   output axi_sram_pkg::axi_resp_t  bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic [`AXI_ID_W-1:0]     arid,
   input  logic [`AXI_ADDR_W-1:0]   araddr,
   input  logic [`AXI_LEN_W-1:0]    arlen,
   input  axi_sram_pkg::axi_size_t  arsize,
   input  axi_sram_pkg::axi_burst_t arburst,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`AXI_ID_W-1:0]     rid,
   output logic [`AXI_DATA_W-1:0]   rdata,
   output axi_sram_pkg::axi_resp_t  rresp,
   output logic                     rlast,
   output logic                     rvalid,
   input  logic                     rready
);

   // sram side, word addressed
   logic [`RAM_ADDR_W-1:0] ram_waddr;
   logic [`AXI_DATA_W-1:0] ram_wdata;
   logic [`AXI_STRB_W-1:0] ram_wen;
   logic [`RAM_ADDR_W-1:0] ram_raddr;
   logic                   ram_ren;
   logic [`AXI_DATA_W-1:0] ram_rdata;

   axi_sram_bridge axi_sram_bridge_i (
      .clk       (clk),
      .resetn    (resetn),
      .awid      (awid),
      .awaddr    (awaddr),
      .awlen     (awlen),
      .awsize    (awsize),
      .awburst   (awburst),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wlast     (wlast),
      .wvalid    (wvalid),
      .wready    (wready),
      .bid       (bid),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .arid      (arid),
      .araddr    (araddr),
      .arlen     (arlen),
      .arsize    (arsize),
      .arburst   (arburst),
      .arvalid   (arvalid),
      .arready   (arready),
      .rid       (rid),
      .rdata     (rdata),
      .rresp     (rresp),
      .rlast     (rlast),
      .rvalid    (rvalid),
      .rready    (rready),
      .ram_waddr (ram_waddr),
      .ram_wdata (ram_wdata),
      .ram_wen   (ram_wen),
      .ram_raddr (ram_raddr),
      .ram_ren   (ram_ren),
      .ram_rdata (ram_rdata)
   );

   sram sram_i (
      .clk   (clk),
      .raddr (ram_raddr),
      .ren   (ram_ren),
      .waddr (ram_waddr),
      .wdata (ram_wdata),
      .wen   (ram_wen),
      .rdata (ram_rdata)
   );

endmodule

/* design/axi_sram_bridge.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_bridge (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [`AXI_ID_W-1:0]     awid,
   input  logic [`AXI_ADDR_W-1:0]   awaddr,
   input  logic [`AXI_LEN_W-1:0]    awlen,
   input  axi_sram_pkg::axi_size_t  awsize,
   input  axi_sram_pkg::axi_burst_t awburst,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`AXI_DATA_W-1:0]   wdata,
   input  logic [`AXI_STRB_W-1:0]   wstrb,
   input  logic                     wlast,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [`AXI_ID_W-1:0]     bid,
   output axi_sram_pkg::axi_resp_t  bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic [`AXI_ID_W-1:0]     arid,
   input  logic [`AXI_ADDR_W-1:0]   araddr,
   input  logic [`AXI_LEN_W-1:0]    arlen,
   input  axi_sram_pkg::axi_size_t  arsize,
   input  axi_sram_pkg::axi_burst_t arburst,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`AXI_ID_W-1:0]     rid,
   output logic [`AXI_DATA_W-1:0]   rdata,
   output axi_sram_pkg::axi_resp_t  rresp,
   output logic                     rlast,
   output logic                     rvalid,
   input  logic                     rready,
   output logic [`RAM_ADDR_W-1:0]   ram_waddr,
   output logic [`AXI_DATA_W-1:0]   ram_wdata,
   output logic [`AXI_STRB_W-1:0]   ram_wen,
   output logic [`RAM_ADDR_W-1:0]   ram_raddr,
   output logic                     ram_ren,
   input  logic [`AXI_DATA_W-1:0]   ram_rdata
);

   logic [`AXI_ADDR_W-1:0] wr_byte_addr;
   logic [`AXI_ADDR_W-1:0] rd_byte_addr;

   // upper address bits are dropped, so the sram aliases
   assign ram_waddr = wr_byte_addr[`RAM_ADDR_W+1:2];
   assign ram_raddr = rd_byte_addr[`RAM_ADDR_W+1:2];

   axi_write_ctrl axi_write_ctrl_i (
      .clk       (clk),
      .resetn    (resetn),
      .awid      (awid),
      .awaddr    (awaddr),
      .awlen     (awlen),
      .awsize    (awsize),
      .awburst   (awburst),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wlast     (wlast),
      .wvalid    (wvalid),
      .wready    (wready),
      .bid       (bid),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .ram_waddr (wr_byte_addr),
      .ram_wdata (ram_wdata),
      .ram_wen   (ram_wen)
   );

   axi_read_ctrl axi_read_ctrl_i (
      .clk       (clk),
      .resetn    (resetn),
      .arid      (arid),
      .araddr    (araddr),
      .arlen     (arlen),
      .arsize    (arsize),
      .arburst   (arburst),
      .arvalid   (arvalid),
      .arready   (arready),
      .rid       (rid),
      .rdata     (rdata),
      .rresp     (rresp),
      .rlast     (rlast),
      .rvalid    (rvalid),
      .rready    (rready),
      .ram_raddr (rd_byte_addr),
      .ram_ren   (ram_ren),
      .ram_rdata (ram_rdata)
   );

endmodule

/* design/axi_read_ctrl.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_read_ctrl (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [`AXI_ID_W-1:0]     arid,
   input  logic [`AXI_ADDR_W-1:0]   araddr,
   input  logic [`AXI_LEN_W-1:0]    arlen,
   input  axi_sram_pkg::axi_size_t  arsize,
   input  axi_sram_pkg::axi_burst_t arburst,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`AXI_ID_W-1:0]     rid,
   output logic [`AXI_DATA_W-1:0]   rdata,
   output axi_sram_pkg::axi_resp_t  rresp,
   output logic                     rlast,
   output logic                     rvalid,
   input  logic                     rready,
   output logic [`AXI_ADDR_W-1:0]   ram_raddr,
   output logic                     ram_ren,
   input  logic [`AXI_DATA_W-1:0]   ram_rdata
);
   import axi_sram_pkg::*;

   typedef enum logic {R_IDLE, R_BURST} rd_state_t;

   rd_state_t              state;
   logic [`AXI_ID_W-1:0]   id_q;
   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`AXI_LEN_W-1:0]  len_q;
   axi_size_t              size_q;
   axi_burst_t             burst_q;
   logic [`AXI_LEN_W:0]    issued_cnt;
   logic [`AXI_LEN_W-1:0]  deliv_cnt;
   logic                   rvalid_q;
   logic                   ar_fire;
   logic                   r_fire;
   logic                   beats_left;

   assign arready = (state == R_IDLE);
   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid_q && rready;

   assign beats_left = (issued_cnt <= {1'b0, len_q});

   // the sram output register is the single beat buffer
   assign ram_ren   = (state == R_BURST) && beats_left && (!rvalid_q || rready);
   assign ram_raddr = addr_q;

   assign rvalid = rvalid_q;
   assign rdata  = ram_rdata;
   assign rid    = id_q;
   assign rresp  = OKAY;
   assign rlast  = rvalid_q && (deliv_cnt == len_q);

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         state      <= R_IDLE;
         rvalid_q   <= 1'b0;
         issued_cnt <= '0;
         deliv_cnt  <= '0;
      end
      else
      begin
         if (ar_fire)
         begin
            state      <= R_BURST;
            issued_cnt <= '0;
            deliv_cnt  <= '0;
         end
         else if (r_fire && rlast)
         begin
            state <= R_IDLE;
         end

         if (ram_ren)
            issued_cnt <= issued_cnt + 1'b1;
         if (r_fire)
            deliv_cnt <= deliv_cnt + 1'b1;

         // data lands one cycle after the read strobe
         if (ram_ren)
            rvalid_q <= 1'b1;
         else if (rready)
            rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         id_q    <= arid;
         addr_q  <= araddr;
         len_q   <= arlen;
         size_q  <= arsize;
         burst_q <= arburst;
      end
      else if (ram_ren)
      begin
         addr_q <= axi_next_addr(addr_q, size_q, burst_q);
      end
   end

endmodule

/* design/axi_write_ctrl.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_write_ctrl (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic [`AXI_ID_W-1:0]     awid,
   input  logic [`AXI_ADDR_W-1:0]   awaddr,
   input  logic [`AXI_LEN_W-1:0]    awlen,
   input  axi_sram_pkg::axi_size_t  awsize,
   input  axi_sram_pkg::axi_burst_t awburst,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`AXI_DATA_W-1:0]   wdata,
   input  logic [`AXI_STRB_W-1:0]   wstrb,
   input  logic                     wlast,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [`AXI_ID_W-1:0]     bid,
   output axi_sram_pkg::axi_resp_t  bresp,
   output logic                     bvalid,
   input  logic                     bready,
   output logic [`AXI_ADDR_W-1:0]   ram_waddr,
   output logic [`AXI_DATA_W-1:0]   ram_wdata,
   output logic [`AXI_STRB_W-1:0]   ram_wen
);
   import axi_sram_pkg::*;

   typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_t;

   wr_state_t              state;
   logic [`AXI_ID_W-1:0]   id_q;
   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`AXI_LEN_W-1:0]  len_q;
   logic [`AXI_LEN_W-1:0]  beat_cnt;
   axi_size_t              size_q;
   axi_burst_t             burst_q;
   logic                   aw_fire;
   logic                   w_fire;
   logic                   burst_done;

   assign awready = (state == W_IDLE);
   assign wready  = (state == W_DATA);
   assign bvalid  = (state == W_RESP);
   assign bid     = id_q;
   assign bresp   = OKAY;

   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;

   // a lost wlast still ends the burst after awlen+1 beats
   assign burst_done = wlast || (beat_cnt == len_q);

   // each w beat goes straight to the sram write port
   assign ram_waddr = addr_q;
   assign ram_wdata = wdata;
   assign ram_wen   = w_fire ? wstrb : '0;

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         state    <= W_IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            W_IDLE:
            begin
               if (aw_fire)
               begin
                  state    <= W_DATA;
                  beat_cnt <= '0;
               end
            end
            W_DATA:
            begin
               if (w_fire)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (burst_done)
                     state <= W_RESP;
               end
            end
            default:
            begin
               if (bready)
                  state <= W_IDLE;
            end
         endcase
      end
   end

   // request fields and beat address
   always_ff @(posedge clk)
   begin
      if (aw_fire)
      begin
         id_q    <= awid;
         addr_q  <= awaddr;
         len_q   <= awlen;
         size_q  <= awsize;
         burst_q <= awburst;
      end
      else if (w_fire)
      begin
         addr_q <= axi_next_addr(addr_q, size_q, burst_q);
      end
   end

endmodule

/* design/sram.sv */
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module sram (
   input  logic                   clk,
   input  logic [`RAM_ADDR_W-1:0] raddr,
   input  logic                   ren,
   input  logic [`RAM_ADDR_W-1:0] waddr,
   input  logic [`AXI_DATA_W-1:0] wdata,
   input  logic [`AXI_STRB_W-1:0] wen,
   output logic [`AXI_DATA_W-1:0] rdata
);

   localparam int DEPTH = 2 ** `RAM_ADDR_W;

   logic [`AXI_DATA_W-1:0] mem [0:DEPTH-1];

   // byte lanes written independently
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `AXI_STRB_W; i++)
      begin
         if (wen[i])
            mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
   end

   // old data on a same-word read and write
   always_ff @(posedge clk)
   begin
      if (ren)
         rdata <= mem[raddr];
   end

endmodule

/* design/axi_sram_pkg.sv */
`include "axi_sram_config.svh"

package axi_sram_pkg;

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_t;

   // bytes per beat is 2**size
   typedef logic [2:0] axi_size_t;

   // wrap bursts step like incr here
   function automatic logic [`AXI_ADDR_W-1:0] axi_next_addr(
      input logic [`AXI_ADDR_W-1:0] addr,
      input axi_size_t              size,
      input axi_burst_t             burst
   );
      logic [`AXI_ADDR_W-1:0] step;
      step = `AXI_ADDR_W'(1) << size;
      if (burst == FIXED)
         return addr;
      return addr + step;
   endfunction

endpackage

/* include/axi_sram_config.svh */
`ifndef AXI_SRAM_CONFIG_SVH
`define AXI_SRAM_CONFIG_SVH

// axi3 slave port widths
`define AXI_ID_W 4
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_LEN_W 4

// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W/8)

// sram word address for 8192 words of 32 bits
`define RAM_ADDR_W 13

`endif
